/* vector_cache_wr.f */
rtl/vector_cache_pkg.sv
rtl/nto4_xbar.sv
rtl/write_req_xbar.sv
rtl/db_entry_alloc.sv
rtl/wdb_bank_buffer.sv
rtl/vector_cache_wr_top.sv
verif/vector_cache_wr_tb.sv

/* verif/vector_cache_wr_tb.sv */
`timescale 1ns/1ps

module vector_cache_wr_tb;
    import vector_cache_pkg::*;

    localparam int WAIT_LIMIT = 2000;
    localparam int EXP_WIDTH  = ADDR_WIDTH + TXNID_WIDTH + SIDEBAND_WIDTH + STRB_WIDTH
                                + DATA_WIDTH + DB_ENTRY_IDX_WIDTH;

    logic                          clk;
    logic                          reset;
    logic [W_REQ_NUM-1:0]          wr_cmd_vld;
    logic [W_REQ_NUM-1:0]          wr_cmd_rdy;
    logic [ADDR_WIDTH-1:0]         wr_cmd_addr         [W_REQ_NUM];
    logic [TXNID_WIDTH-1:0]        wr_cmd_txnid        [W_REQ_NUM];
    logic [SIDEBAND_WIDTH-1:0]     wr_cmd_sideband     [W_REQ_NUM];
    logic [STRB_WIDTH-1:0]         wr_cmd_strb         [W_REQ_NUM];
    logic [DATA_WIDTH-1:0]         wr_cmd_data         [W_REQ_NUM];
    logic [BANK_NUM-1:0]           bank_wr_vld;
    logic [BANK_NUM-1:0]           bank_wr_rdy;
    logic [ADDR_WIDTH-1:0]         bank_wr_addr        [BANK_NUM];
    logic [TXNID_WIDTH-1:0]        bank_wr_txnid       [BANK_NUM];
    logic [SIDEBAND_WIDTH-1:0]     bank_wr_sideband    [BANK_NUM];
    logic [STRB_WIDTH-1:0]         bank_wr_strb        [BANK_NUM];
    logic [DATA_WIDTH-1:0]         bank_wr_data        [BANK_NUM];
    logic [DB_ENTRY_IDX_WIDTH-1:0] bank_wr_db_entry_id [BANK_NUM];

    // reference model state
    logic [EXP_WIDTH-1:0]    exp_q      [BANK_NUM][$];
    logic [TXNID_WIDTH-1:0]  seen_txnid [BANK_NUM][$];
    logic [DB_ENTRY_NUM-1:0] in_use     [BANK_NUM];     // outstanding entry ids
    int                      rr_ptr     [BANK_NUM];
    logic [31:0]             rng_state = 32'hfe94_f101;
    logic [TXNID_WIDTH-1:0]  txn_cnt;
    string                   test_name;

    vector_cache_wr_top dut (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic int rr_pick(input logic [W_REQ_NUM-1:0] mask, input int ptr);
        int idx;
        for (int k = 0; k < W_REQ_NUM; k++) begin
            idx = (ptr + k) % W_REQ_NUM;
            if (mask[idx]) return idx;
        end
        return -1;
    endfunction

    function automatic int lowest_free(input logic [DB_ENTRY_NUM-1:0] used);
        for (int i = 0; i < DB_ENTRY_NUM; i++) begin
            if (!used[i]) return i;
        end
        return 0;
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int b = 0; b < BANK_NUM; b++) n += exp_q[b].size();
        return n;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_equal(input string what, input logic [127:0] exp,
                               input logic [127:0] act);
        if (exp !== act) begin
            abort_run($sformatf("ERR %s %s expected %0h actual %0h", test_name, what, exp, act));
        end
    endtask

    task automatic apply_reset();
        reset       = 1'b1;
        wr_cmd_vld  = '0;
        bank_wr_rdy = '1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    // random payload with the address built from the field view
    task automatic set_req(input int m, input logic [BANK_SEL_WIDTH-1:0] bank,
                           input logic [TXNID_WIDTH-1:0] txnid);
        cmd_addr_u a;
        a.field.bank_sel   = bank;
        a.field.line_addr  = LINE_ADDR_WIDTH'({next_rand(), next_rand()});
        a.field.beat_ofs   = BEAT_OFS_WIDTH'(next_rand());
        wr_cmd_addr[m]     = a.raw;
        wr_cmd_txnid[m]    = txnid;
        wr_cmd_sideband[m] = SIDEBAND_WIDTH'(next_rand());
        wr_cmd_strb[m]     = STRB_WIDTH'(next_rand());
        wr_cmd_data[m]     = {next_rand(), next_rand(), next_rand(), next_rand()};
        wr_cmd_vld[m]      = 1'b1;
    endtask

    // hold each request until it transfers
    // later rounds keep the bank and add 0x10 to the txnid
    task automatic send_pending(input int rounds);
        int left [W_REQ_NUM];
        logic [W_REQ_NUM-1:0] acc;
        int cycles;
        cycles = 0;
        foreach (left[m]) left[m] = rounds - 1;
        while (wr_cmd_vld != '0) begin
            @(negedge clk);
            acc = wr_cmd_vld & wr_cmd_rdy;
            @(posedge clk);
            #1;
            for (int m = 0; m < W_REQ_NUM; m++) begin
                if (acc[m] && left[m] > 0) begin
                    left[m]--;
                    set_req(m, wr_cmd_addr[m][ADDR_WIDTH-1 -: BANK_SEL_WIDTH],
                            wr_cmd_txnid[m] + 8'h10);
                end else if (acc[m]) begin
                    wr_cmd_vld[m] = 1'b0;
                end
            end
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run("timeout waiting for master requests to be accepted");
            end
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (pending_count() != 0) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > WAIT_LIMIT) abort_run("timeout waiting for bank ports to drain");
        end
    endtask

    // reference model step at each negedge
    task automatic observe_cycle();
        logic [W_REQ_NUM-1:0]          mask;
        int                            win [BANK_NUM];
        logic [DB_ENTRY_IDX_WIDTH-1:0] free_id [BANK_NUM];
        int                            bk;
        logic [ADDR_WIDTH-1:0]         e_addr;
        logic [TXNID_WIDTH-1:0]        e_txnid;
        logic [SIDEBAND_WIDTH-1:0]     e_sb;
        logic [STRB_WIDTH-1:0]         e_strb;
        logic [DATA_WIDTH-1:0]         e_data;
        logic [DB_ENTRY_IDX_WIDTH-1:0] e_id;
        for (int b = 0; b < BANK_NUM; b++) begin
            for (int m = 0; m < W_REQ_NUM; m++) begin
                mask[m] = wr_cmd_vld[m] && (wr_cmd_addr[m][ADDR_WIDTH-1 -: BANK_SEL_WIDTH] == b);
            end
            win[b]     = rr_pick(mask, rr_ptr[b]);
            free_id[b] = DB_ENTRY_IDX_WIDTH'(lowest_free(in_use[b]));  // before this cycle's pops
        end
        for (int m = 0; m < W_REQ_NUM; m++) begin
            bk = wr_cmd_addr[m][ADDR_WIDTH-1 -: BANK_SEL_WIDTH];
            check_equal($sformatf("wr_cmd_rdy[%0d]", m),
                        wr_cmd_vld[m] && win[bk] == m && $countones(in_use[bk]) < DB_ENTRY_NUM,
                        wr_cmd_rdy[m]);
        end
        for (int b = 0; b < BANK_NUM; b++) begin
            check_equal($sformatf("bank_wr_vld[%0d]", b), exp_q[b].size() != 0, bank_wr_vld[b]);
        end
        for (int b = 0; b < BANK_NUM; b++) begin
            if (bank_wr_vld[b] && bank_wr_rdy[b]) begin
                if (exp_q[b].size() == 0) begin
                    abort_run($sformatf("bank %0d sent a request that was never accepted", b));
                end else begin
                    {e_addr, e_txnid, e_sb, e_strb, e_data, e_id} = exp_q[b].pop_front();
                    check_equal("bank_wr_addr", e_addr, bank_wr_addr[b]);
                    check_equal("bank_wr_txnid", e_txnid, bank_wr_txnid[b]);
                    check_equal("bank_wr_sideband", e_sb, bank_wr_sideband[b]);
                    check_equal("bank_wr_strb", e_strb, bank_wr_strb[b]);
                    check_equal("bank_wr_data", e_data, bank_wr_data[b]);
                    check_equal("bank_wr_db_entry_id", e_id, bank_wr_db_entry_id[b]);
                    in_use[b][e_id] = 1'b0;
                    seen_txnid[b].push_back(bank_wr_txnid[b]);
                end
            end
        end
        for (int m = 0; m < W_REQ_NUM; m++) begin
            if (wr_cmd_vld[m] && wr_cmd_rdy[m]) begin
                bk   = wr_cmd_addr[m][ADDR_WIDTH-1 -: BANK_SEL_WIDTH];
                e_id = free_id[bk];
                in_use[bk][e_id] = 1'b1;
                exp_q[bk].push_back({wr_cmd_addr[m], wr_cmd_txnid[m], wr_cmd_sideband[m],
                                     wr_cmd_strb[m], wr_cmd_data[m], e_id});
                rr_ptr[bk] = (m + 1) % W_REQ_NUM;
            end
        end
    endtask

    always @(negedge clk) begin
        if (reset) begin
            for (int b = 0; b < BANK_NUM; b++) begin
                exp_q[b].delete();
                seen_txnid[b].delete();
                in_use[b] = '0;
                rr_ptr[b] = 0;
            end
        end else begin
            observe_cycle();
        end
    end

    task automatic single_route();
        test_name = "single_route";
        apply_reset();
        for (int b = 0; b < BANK_NUM; b++) begin
            set_req(b, BANK_SEL_WIDTH'(BANK_NUM - 1 - b), TXNID_WIDTH'(8'h20 + b));
            send_pending(1);
            wait_drain();
        end
        for (int b = 0; b < BANK_NUM; b++) begin
            check_equal("requests at bank", 1, seen_txnid[b].size());
            check_equal("txnid at bank", 8'h20 + BANK_NUM - 1 - b, seen_txnid[b][0]);
        end
    endtask

    task automatic rr_fairness();
        int left [W_REQ_NUM];
        logic [W_REQ_NUM-1:0] mask;
        int ptr;
        int w;
        test_name = "rr_fairness";
        apply_reset();
        for (int m = 0; m < W_REQ_NUM; m++) begin
            set_req(m, 2'd2, TXNID_WIDTH'(m));
            left[m] = 2;
        end
        send_pending(2);
        wait_drain();
        check_equal("requests at bank 2", 2 * W_REQ_NUM, seen_txnid[2].size());
        ptr = 0;
        for (int i = 0; i < 2 * W_REQ_NUM; i++) begin
            for (int m = 0; m < W_REQ_NUM; m++) mask[m] = (left[m] > 0);
            w = rr_pick(mask, ptr);
            check_equal($sformatf("txnid %0d", i), w + 16 * (2 - left[w]), seen_txnid[2][i]);
            left[w]--;
            ptr = (w + 1) % W_REQ_NUM;
        end
    endtask

    task automatic parallel_banks();
        test_name = "parallel_banks";
        apply_reset();
        for (int m = 0; m < W_REQ_NUM; m++) begin
            set_req(m, BANK_SEL_WIDTH'((m + 1) % BANK_NUM), TXNID_WIDTH'(8'h40 + m));
        end
        @(negedge clk);
        check_equal("wr_cmd_rdy all", {W_REQ_NUM{1'b1}}, wr_cmd_rdy);
        @(posedge clk);
        #1;
        wr_cmd_vld = '0;
        wait_drain();
        for (int b = 0; b < BANK_NUM; b++) begin
            check_equal("requests at bank", 1, seen_txnid[b].size());
            check_equal("txnid at bank", 8'h40 + (b + BANK_NUM - 1) % BANK_NUM, seen_txnid[b][0]);
        end
    endtask

    task automatic buffer_full();
        test_name = "buffer_full";
        apply_reset();
        bank_wr_rdy[1] = 1'b0;
        for (int i = 0; i < DB_ENTRY_NUM; i++) begin
            set_req(0, 2'd1, TXNID_WIDTH'(i));
            send_pending(1);
        end
        set_req(1, 2'd1, 8'h08);
        set_req(2, 2'd3, 8'h30);
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_equal("ninth request rdy", 0, wr_cmd_rdy[1]);
            if (i == 0) check_equal("bank 3 request rdy", 1, wr_cmd_rdy[2]);
            @(posedge clk);
            #1;
            wr_cmd_vld[2] = 1'b0;
        end
        bank_wr_rdy[1] = 1'b1;
        send_pending(1);
        wait_drain();
        check_equal("requests at bank 1", DB_ENTRY_NUM + 1, seen_txnid[1].size());
        for (int i = 0; i <= DB_ENTRY_NUM; i++) begin
            check_equal($sformatf("bank 1 txnid %0d", i), i, seen_txnid[1][i]);
        end
        check_equal("txnid at bank 3", 8'h30, seen_txnid[3][0]);
    endtask

    task automatic random_traffic();
        logic [W_REQ_NUM-1:0] acc;
        logic [31:0] r;
        test_name = "random_traffic";
        apply_reset();
        for (int cyc = 0; cyc < 400; cyc++) begin
            @(negedge clk);
            acc = wr_cmd_vld & wr_cmd_rdy;
            @(posedge clk);
            #1;
            wr_cmd_vld = wr_cmd_vld & ~acc;
            r = next_rand();
            for (int m = 0; m < W_REQ_NUM; m++) begin
                if (!wr_cmd_vld[m] && r[m]) begin
                    set_req(m, r[2*m+8 +: 2], txn_cnt);
                    txn_cnt++;
                end
            end
            bank_wr_rdy = r[23:20];   // bank back pressure
        end
        bank_wr_rdy = '1;
        send_pending(1);
        wait_drain();
    endtask

    initial begin
        reset       = 1'b1;
        wr_cmd_vld  = '0;
        bank_wr_rdy = '1;
        txn_cnt     = '0;
        for (int m = 0; m < W_REQ_NUM; m++) begin
            wr_cmd_addr[m]     = '0;
            wr_cmd_txnid[m]    = '0;
            wr_cmd_sideband[m] = '0;
            wr_cmd_strb[m]     = '0;
            wr_cmd_data[m]     = '0;
        end
        single_route();
        rr_fairness();
        parallel_banks();
        buffer_full();
        random_traffic();
        $display("All tests passed");
        $finish;
    end

endmodule

/* rtl/vector_cache_wr_top.sv */
`timescale 1ns/1ps

module vector_cache_wr_top (
    input  logic clk,
    input  logic reset,

    input  logic [vector_cache_pkg::W_REQ_NUM-1:0] wr_cmd_vld,
    output logic [vector_cache_pkg::W_REQ_NUM-1:0] wr_cmd_rdy,
    input  logic [vector_cache_pkg::ADDR_WIDTH-1:0] wr_cmd_addr [vector_cache_pkg::W_REQ_NUM],
    input  logic [vector_cache_pkg::TXNID_WIDTH-1:0]
                 wr_cmd_txnid [vector_cache_pkg::W_REQ_NUM],
    input  logic [vector_cache_pkg::SIDEBAND_WIDTH-1:0]
                 wr_cmd_sideband [vector_cache_pkg::W_REQ_NUM],
    input  logic [vector_cache_pkg::STRB_WIDTH-1:0] wr_cmd_strb [vector_cache_pkg::W_REQ_NUM],
    input  logic [vector_cache_pkg::DATA_WIDTH-1:0] wr_cmd_data [vector_cache_pkg::W_REQ_NUM],

    output logic [vector_cache_pkg::BANK_NUM-1:0] bank_wr_vld,
    input  logic [vector_cache_pkg::BANK_NUM-1:0] bank_wr_rdy,
    output logic [vector_cache_pkg::ADDR_WIDTH-1:0] bank_wr_addr [vector_cache_pkg::BANK_NUM],
    output logic [vector_cache_pkg::TXNID_WIDTH-1:0]
                 bank_wr_txnid [vector_cache_pkg::BANK_NUM],
    output logic [vector_cache_pkg::SIDEBAND_WIDTH-1:0]
                 bank_wr_sideband [vector_cache_pkg::BANK_NUM],
    output logic [vector_cache_pkg::STRB_WIDTH-1:0] bank_wr_strb [vector_cache_pkg::BANK_NUM],
    output logic [vector_cache_pkg::DATA_WIDTH-1:0] bank_wr_data [vector_cache_pkg::BANK_NUM],
    output logic [vector_cache_pkg::DB_ENTRY_IDX_WIDTH-1:0]
                 bank_wr_db_entry_id [vector_cache_pkg::BANK_NUM]
);
    import vector_cache_pkg::*;

    logic [BANK_NUM-1:0]           alloc_vld;
    logic [DB_ENTRY_IDX_WIDTH-1:0] alloc_idx     [BANK_NUM];
    logic [BANK_NUM-1:0]           alloc_take;
    logic [BANK_NUM-1:0]           push_vld;
    logic [DB_ENTRY_IDX_WIDTH-1:0] push_entry    [BANK_NUM];
    logic [ADDR_WIDTH-1:0]         push_addr     [BANK_NUM];
    logic [TXNID_WIDTH-1:0]        push_txnid    [BANK_NUM];
    logic [SIDEBAND_WIDTH-1:0]     push_sideband [BANK_NUM];
    logic [STRB_WIDTH-1:0]         push_strb     [BANK_NUM];
    logic [DATA_WIDTH-1:0]         push_data     [BANK_NUM];
    logic [BANK_NUM-1:0]           free_vld;
    logic [DB_ENTRY_IDX_WIDTH-1:0] free_entry    [BANK_NUM];

    write_req_xbar u_req_xbar (
        .clk             (clk),
        .reset           (reset),
        .wr_cmd_vld      (wr_cmd_vld),
        .wr_cmd_rdy      (wr_cmd_rdy),
        .wr_cmd_addr     (wr_cmd_addr),
        .wr_cmd_txnid    (wr_cmd_txnid),
        .wr_cmd_sideband (wr_cmd_sideband),
        .wr_cmd_strb     (wr_cmd_strb),
        .wr_cmd_data     (wr_cmd_data),
        .alloc_vld       (alloc_vld),
        .alloc_idx       (alloc_idx),
        .alloc_take      (alloc_take),
        .push_vld        (push_vld),
        .push_entry      (push_entry),
        .push_addr       (push_addr),
        .push_txnid      (push_txnid),
        .push_sideband   (push_sideband),
        .push_strb       (push_strb),
        .push_data       (push_data)
    );

    for (genvar b = 0; b < BANK_NUM; b++) begin : g_bank
        db_entry_alloc u_alloc (
            .clk        (clk),
            .reset      (reset),
            .alloc_vld  (alloc_vld[b]),
            .alloc_idx  (alloc_idx[b]),
            .alloc_take (alloc_take[b]),
            .free_vld   (free_vld[b]),
            .free_entry (free_entry[b])
        );

        wdb_bank_buffer u_wdb (
            .clk                 (clk),
            .reset               (reset),
            .push_vld            (push_vld[b]),
            .push_entry          (push_entry[b]),
            .push_addr           (push_addr[b]),
            .push_txnid          (push_txnid[b]),
            .push_sideband       (push_sideband[b]),
            .push_strb           (push_strb[b]),
            .push_data           (push_data[b]),
            .bank_wr_vld         (bank_wr_vld[b]),
            .bank_wr_rdy         (bank_wr_rdy[b]),
            .bank_wr_addr        (bank_wr_addr[b]),
            .bank_wr_txnid       (bank_wr_txnid[b]),
            .bank_wr_sideband    (bank_wr_sideband[b]),
            .bank_wr_strb        (bank_wr_strb[b]),
            .bank_wr_data        (bank_wr_data[b]),
            .bank_wr_db_entry_id (bank_wr_db_entry_id[b]),
            .free_vld            (free_vld[b]),
            .free_entry          (free_entry[b])
        );
    end

endmodule

/* rtl/wdb_bank_buffer.sv */
`timescale 1ns/1ps

module wdb_bank_buffer (
    input  logic clk,
    input  logic reset,

    input  logic                                            push_vld,
    input  logic [vector_cache_pkg::DB_ENTRY_IDX_WIDTH-1:0] push_entry,
    input  logic [vector_cache_pkg::ADDR_WIDTH-1:0]         push_addr,
    input  logic [vector_cache_pkg::TXNID_WIDTH-1:0]        push_txnid,
    input  logic [vector_cache_pkg::SIDEBAND_WIDTH-1:0]     push_sideband,
    input  logic [vector_cache_pkg::STRB_WIDTH-1:0]         push_strb,
    input  logic [vector_cache_pkg::DATA_WIDTH-1:0]         push_data,

    output logic                                            bank_wr_vld,
    input  logic                                            bank_wr_rdy,
    output logic [vector_cache_pkg::ADDR_WIDTH-1:0]         bank_wr_addr,
    output logic [vector_cache_pkg::TXNID_WIDTH-1:0]        bank_wr_txnid,
    output logic [vector_cache_pkg::SIDEBAND_WIDTH-1:0]     bank_wr_sideband,
    output logic [vector_cache_pkg::STRB_WIDTH-1:0]         bank_wr_strb,
    output logic [vector_cache_pkg::DATA_WIDTH-1:0]         bank_wr_data,
    output logic [vector_cache_pkg::DB_ENTRY_IDX_WIDTH-1:0] bank_wr_db_entry_id,

    output logic                                            free_vld,
    output logic [vector_cache_pkg::DB_ENTRY_IDX_WIDTH-1:0] free_entry
);
    import vector_cache_pkg::*;

    // payload storage, indexed by entry id
    logic [ADDR_WIDTH-1:0]     mem_addr     [DB_ENTRY_NUM];
    logic [TXNID_WIDTH-1:0]    mem_txnid    [DB_ENTRY_NUM];
    logic [SIDEBAND_WIDTH-1:0] mem_sideband [DB_ENTRY_NUM];
    logic [STRB_WIDTH-1:0]     mem_strb     [DB_ENTRY_NUM];
    logic [DATA_WIDTH-1:0]     mem_data     [DB_ENTRY_NUM];

    logic [DB_ENTRY_IDX_WIDTH-1:0] order [DB_ENTRY_NUM];   // entry ids in arrival order
    logic [DB_ENTRY_IDX_WIDTH-1:0] wr_ptr;
    logic [DB_ENTRY_IDX_WIDTH-1:0] rd_ptr;
    logic [DB_ENTRY_IDX_WIDTH:0]   count;
    logic [DB_ENTRY_IDX_WIDTH-1:0] head;
    logic                          pop;

    always_ff @(posedge clk) begin
        if (push_vld) begin
            mem_addr[push_entry]     <= push_addr;
            mem_txnid[push_entry]    <= push_txnid;
            mem_sideband[push_entry] <= push_sideband;
            mem_strb[push_entry]     <= push_strb;
            mem_data[push_entry]     <= push_data;
            order[wr_ptr]            <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_vld) wr_ptr <= wr_ptr + 1'b1;  // wraps at DB_ENTRY_NUM
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + push_vld - pop;
        end
    end

    assign head        = order[rd_ptr];
    assign bank_wr_vld = (count != '0);
    assign pop         = bank_wr_vld && bank_wr_rdy;

    assign bank_wr_addr        = mem_addr[head];
    assign bank_wr_txnid       = mem_txnid[head];
    assign bank_wr_sideband    = mem_sideband[head];
    assign bank_wr_strb        = mem_strb[head];
    assign bank_wr_data        = mem_data[head];
    assign bank_wr_db_entry_id = head;

    // head entry goes back to the allocator as it leaves
    assign free_vld   = pop;
    assign free_entry = head;

endmodule

/* rtl/db_entry_alloc.sv */
`timescale 1ns/1ps

module db_entry_alloc (
    input  logic clk,
    input  logic reset,

    output logic                                          alloc_vld,
    output logic [vector_cache_pkg::DB_ENTRY_IDX_WIDTH-1:0] alloc_idx,
    input  logic                                          alloc_take,

    input  logic                                          free_vld,
    input  logic [vector_cache_pkg::DB_ENTRY_IDX_WIDTH-1:0] free_entry
);
    import vector_cache_pkg::*;

    logic [DB_ENTRY_NUM-1:0] free_bits;   // 1 = entry free
    logic [DB_ENTRY_NUM-1:0] free_nxt;

    assign alloc_vld = |free_bits;

    // lowest free entry
    always_comb begin
        alloc_idx = '0;
        for (int i = DB_ENTRY_NUM - 1; i >= 0; i--) begin
            if (free_bits[i]) alloc_idx = DB_ENTRY_IDX_WIDTH'(i);
        end
    end

    // take and release never hit the same entry
    always_comb begin
        free_nxt = free_bits;
        if (alloc_take) begin
            free_nxt[alloc_idx] = 1'b0;
        end
        if (free_vld) begin
            free_nxt[free_entry] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            free_bits <= '1;    // all entries free
        end else begin
            free_bits <= free_nxt;
        end
    end

endmodule

/* rtl/write_req_xbar.sv */
`timescale 1ns/1ps

module write_req_xbar (
    input  logic clk,
    input  logic reset,

    input  logic [vector_cache_pkg::W_REQ_NUM-1:0] wr_cmd_vld,
    output logic [vector_cache_pkg::W_REQ_NUM-1:0] wr_cmd_rdy,
    input  logic [vector_cache_pkg::ADDR_WIDTH-1:0] wr_cmd_addr [vector_cache_pkg::W_REQ_NUM],
    input  logic [vector_cache_pkg::TXNID_WIDTH-1:0]
                 wr_cmd_txnid [vector_cache_pkg::W_REQ_NUM],
    input  logic [vector_cache_pkg::SIDEBAND_WIDTH-1:0]
                 wr_cmd_sideband [vector_cache_pkg::W_REQ_NUM],
    input  logic [vector_cache_pkg::STRB_WIDTH-1:0] wr_cmd_strb [vector_cache_pkg::W_REQ_NUM],
    input  logic [vector_cache_pkg::DATA_WIDTH-1:0] wr_cmd_data [vector_cache_pkg::W_REQ_NUM],

    input  logic [vector_cache_pkg::BANK_NUM-1:0] alloc_vld,
    input  logic [vector_cache_pkg::DB_ENTRY_IDX_WIDTH-1:0]
                 alloc_idx [vector_cache_pkg::BANK_NUM],
    output logic [vector_cache_pkg::BANK_NUM-1:0] alloc_take,

    output logic [vector_cache_pkg::BANK_NUM-1:0] push_vld,
    output logic [vector_cache_pkg::DB_ENTRY_IDX_WIDTH-1:0]
                 push_entry [vector_cache_pkg::BANK_NUM],
    output logic [vector_cache_pkg::ADDR_WIDTH-1:0] push_addr [vector_cache_pkg::BANK_NUM],
    output logic [vector_cache_pkg::TXNID_WIDTH-1:0] push_txnid [vector_cache_pkg::BANK_NUM],
    output logic [vector_cache_pkg::SIDEBAND_WIDTH-1:0]
                 push_sideband [vector_cache_pkg::BANK_NUM],
    output logic [vector_cache_pkg::STRB_WIDTH-1:0] push_strb [vector_cache_pkg::BANK_NUM],
    output logic [vector_cache_pkg::DATA_WIDTH-1:0] push_data [vector_cache_pkg::BANK_NUM]
);
    import vector_cache_pkg::*;

    cmd_addr_u                 addr_view [W_REQ_NUM];
    logic [BANK_SEL_WIDTH-1:0] in_select [W_REQ_NUM];
    logic [BANK_NUM-1:0]       sel_vld;
    logic [BANK_NUM-1:0]       xfer;

    for (genvar m = 0; m < W_REQ_NUM; m++) begin : g_sel
        assign addr_view[m].raw = wr_cmd_addr[m];
        assign in_select[m]     = addr_view[m].field.bank_sel;
    end

    // a grant only counts when the bank has a free entry
    nto4_xbar u_xbar (
        .clk          (clk),
        .reset        (reset),
        .in_vld       (wr_cmd_vld),
        .in_rdy       (wr_cmd_rdy),
        .in_select    (in_select),
        .in_addr      (wr_cmd_addr),
        .in_txnid     (wr_cmd_txnid),
        .in_sideband  (wr_cmd_sideband),
        .in_strb      (wr_cmd_strb),
        .in_data      (wr_cmd_data),
        .sel_vld      (sel_vld),
        .sel_rdy      (alloc_vld),
        .sel_addr     (push_addr),
        .sel_txnid    (push_txnid),
        .sel_sideband (push_sideband),
        .sel_strb     (push_strb),
        .sel_data     (push_data)
    );

    assign xfer       = sel_vld & alloc_vld;
    assign alloc_take = xfer;   // pulse, one entry per transfer
    assign push_vld   = xfer;

    for (genvar b = 0; b < BANK_NUM; b++) begin : g_entry
        assign push_entry[b] = alloc_idx[b];
    end

endmodule

/* rtl/nto4_xbar.sv */
`timescale 1ns/1ps

module nto4_xbar (
    input  logic clk,
    input  logic reset,

    input  logic [vector_cache_pkg::W_REQ_NUM-1:0] in_vld,
    output logic [vector_cache_pkg::W_REQ_NUM-1:0] in_rdy,
    input  logic [vector_cache_pkg::BANK_SEL_WIDTH-1:0]
                 in_select [vector_cache_pkg::W_REQ_NUM],
    input  logic [vector_cache_pkg::ADDR_WIDTH-1:0] in_addr [vector_cache_pkg::W_REQ_NUM],
    input  logic [vector_cache_pkg::TXNID_WIDTH-1:0] in_txnid [vector_cache_pkg::W_REQ_NUM],
    input  logic [vector_cache_pkg::SIDEBAND_WIDTH-1:0]
                 in_sideband [vector_cache_pkg::W_REQ_NUM],
    input  logic [vector_cache_pkg::STRB_WIDTH-1:0] in_strb [vector_cache_pkg::W_REQ_NUM],
    input  logic [vector_cache_pkg::DATA_WIDTH-1:0] in_data [vector_cache_pkg::W_REQ_NUM],

    output logic [vector_cache_pkg::BANK_NUM-1:0] sel_vld,
    input  logic [vector_cache_pkg::BANK_NUM-1:0] sel_rdy,
    output logic [vector_cache_pkg::ADDR_WIDTH-1:0] sel_addr [vector_cache_pkg::BANK_NUM],
    output logic [vector_cache_pkg::TXNID_WIDTH-1:0] sel_txnid [vector_cache_pkg::BANK_NUM],
    output logic [vector_cache_pkg::SIDEBAND_WIDTH-1:0]
                 sel_sideband [vector_cache_pkg::BANK_NUM],
    output logic [vector_cache_pkg::STRB_WIDTH-1:0] sel_strb [vector_cache_pkg::BANK_NUM],
    output logic [vector_cache_pkg::DATA_WIDTH-1:0] sel_data [vector_cache_pkg::BANK_NUM]
);
    import vector_cache_pkg::*;

    logic [REQ_IDX_WIDTH-1:0] ptr [BANK_NUM];   // next master with top priority
    logic [REQ_IDX_WIDTH-1:0] win [BANK_NUM];

    for (genvar b = 0; b < BANK_NUM; b++) begin : g_bank
        logic [W_REQ_NUM-1:0] req;

        for (genvar m = 0; m < W_REQ_NUM; m++) begin : g_req
            assign req[m] = in_vld[m] && (in_select[m] == BANK_SEL_WIDTH'(b));
        end

        assign sel_vld[b] = |req;

        // first requester at or after ptr, wrapping
        always_comb begin
            int unsigned idx;
            win[b] = '0;
            for (int k = W_REQ_NUM - 1; k >= 0; k--) begin
                idx = (ptr[b] + k) % W_REQ_NUM;
                if (req[idx]) win[b] = REQ_IDX_WIDTH'(idx);
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                ptr[b] <= '0;
            end else if (sel_vld[b] && sel_rdy[b]) begin
                ptr[b] <= (win[b] == REQ_IDX_WIDTH'(W_REQ_NUM - 1)) ? '0 : win[b] + 1'b1;
            end
        end

        assign sel_addr[b]     = in_addr[win[b]];
        assign sel_txnid[b]    = in_txnid[win[b]];
        assign sel_sideband[b] = in_sideband[win[b]];
        assign sel_strb[b]     = in_strb[win[b]];
        assign sel_data[b]     = in_data[win[b]];
    end

    for (genvar m = 0; m < W_REQ_NUM; m++) begin : g_rdy
        assign in_rdy[m] = sel_vld[in_select[m]] && sel_rdy[in_select[m]]
                           && (win[in_select[m]] == REQ_IDX_WIDTH'(m));
    end

endmodule

/* rtl/vector_cache_pkg.sv */
package vector_cache_pkg;

    localparam int W_REQ_NUM      = 4;
    localparam int REQ_IDX_WIDTH  = 2;  // $clog2(W_REQ_NUM)
    localparam int BANK_NUM       = 4;
    localparam int BANK_SEL_WIDTH = 2;

    localparam int ADDR_WIDTH     = 64;
    localparam int DATA_WIDTH     = 128;
    localparam int STRB_WIDTH     = DATA_WIDTH / 8;
    localparam int TXNID_WIDTH    = 8;
    localparam int SIDEBAND_WIDTH = 4;

    localparam int DB_ENTRY_NUM       = 8;
    localparam int DB_ENTRY_IDX_WIDTH = 3;

    // byte offset inside one 16 byte beat
    localparam int BEAT_OFS_WIDTH  = 4;
    localparam int LINE_ADDR_WIDTH = ADDR_WIDTH - BANK_SEL_WIDTH - BEAT_OFS_WIDTH;

    // one address word, seen raw or split into fields
    typedef union packed {
        logic [ADDR_WIDTH-1:0] raw;
        struct packed {
            logic [BANK_SEL_WIDTH-1:0]  bank_sel;   // bits 63:62
            logic [LINE_ADDR_WIDTH-1:0] line_addr;
            logic [BEAT_OFS_WIDTH-1:0]  beat_ofs;
        } field;
    } cmd_addr_u;

endpackage
